// ==== bench/muldiv_tb.sv ====
module muldiv_tb;
	timeunit 1ns;
	timeprecision 1ps;

	// ----------------------------------------
	// test sizes and run limit
	// ----------------------------------------

	localparam int n_mul    = 300;
	localparam int n_div    = 300;
	localparam int n_corner = 16;
	localparam int n_b2b    = 40;
	// each op takes its latency plus the ready pulse and the idle edge.
	localparam int cycle_limit =
		(n_mul + n_div + n_corner + n_b2b + 1) * (muldiv_pkg::div_latency + 4) + 100;

	logic                   clk;
	logic                   rst_n;
	logic                   valid;
	muldiv_pkg::muldiv_op_t op;
	muldiv_pkg::xlen_t      operand_a;
	muldiv_pkg::xlen_t      operand_b;
	logic                   ready;
	muldiv_pkg::xlen_t      result;

	integer            seed;
	int                checks;
	int                errors;
	int                test_checks;
	int                test_errors;
	// value the result register should hold between operations.
	muldiv_pkg::xlen_t last_result;

	muldiv_unit dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid     (valid),
		.op        (op),
		.operand_a (operand_a),
		.operand_b (operand_b),
		.ready     (ready),
		.result    (result)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// watchdog on total cycles.
	initial begin
		int cycle_count;
		cycle_count = 0;
		while (cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout: run did not finish within %0d cycles", cycle_limit);
		$display("FAIL: see errors above");
		$finish;
	end

	// ----------------------------------------
	// reference arithmetic
	// ----------------------------------------

	// RISC-V M results from 64-bit arithmetic.
	function automatic muldiv_pkg::xlen_t expected_result(muldiv_pkg::muldiv_op_t o,
			muldiv_pkg::xlen_t a, muldiv_pkg::xlen_t b);
		longint          sa;
		longint          sb;
		longint unsigned ua;
		longint unsigned ub;
		logic [63:0]     wide;
		sa = longint'($signed(a));
		sb = longint'($signed(b));
		ua = {32'd0, a};
		ub = {32'd0, b};
		wide = '0;
		case (o)
			muldiv_pkg::op_mul:    wide = sa * sb;
			muldiv_pkg::op_mulh:   wide = sa * sb;
			muldiv_pkg::op_mulhsu: wide = sa * longint'(ub);
			muldiv_pkg::op_mulhu:  wide = ua * ub;
			// by zero, quotient is all ones and remainder is the dividend.
			muldiv_pkg::op_div:    wide = (b == '0) ? longint'(-1) : sa / sb;
			muldiv_pkg::op_divu:   wide = (b == '0) ? '1 : ua / ub;
			muldiv_pkg::op_rem:    wide = (b == '0) ? sa : sa % sb;
			muldiv_pkg::op_remu:   wide = (b == '0) ? ua : ua % ub;
			default:               wide = '0;
		endcase
		// high word only for the mulh family.
		if (o == muldiv_pkg::op_mulh || o == muldiv_pkg::op_mulhsu ||
		    o == muldiv_pkg::op_mulhu) begin
			return wide[63:32];
		end
		return wide[31:0];
	endfunction

	// ----------------------------------------
	// checks and stimulus helpers
	// ----------------------------------------

	task automatic check_value(string what, muldiv_pkg::xlen_t got, muldiv_pkg::xlen_t want);
		test_checks++;
		assert (got == want) else begin
			$display("mismatch at %0t ns: %s is %h, expected %h", $time, what, got, want);
			test_errors++;
		end
	endtask

	task automatic check_ready(logic want);
		test_checks++;
		assert (ready == want) else begin
			$display("mismatch at %0t ns: ready is %b, expected %b", $time, ready, want);
			test_errors++;
		end
	endtask

	// each corner value comes up one time in eight.
	task automatic pick_operand(output muldiv_pkg::xlen_t v);
		int r;
		r = $random(seed);
		case (r[2:0])
			3'd0:    v = '0;
			3'd1:    v = 32'd1;
			3'd2:    v = '1;
			3'd3:    v = 32'h8000_0000;
			default: v = $random(seed);
		endcase
	endtask

	// inputs are don't care after the sampling edge.
	task automatic scramble_inputs();
		int r;
		r = $random(seed);
		op        = muldiv_pkg::muldiv_op_t'(r[2:0]);
		operand_a = $random(seed);
		operand_b = $random(seed);
	endtask

	// starts at a falling edge with the unit idle and ready low.
	task automatic run_op(muldiv_pkg::muldiv_op_t o, muldiv_pkg::xlen_t a,
			muldiv_pkg::xlen_t b, bit hold_valid);
		muldiv_pkg::xlen_t want;
		int                latency;
		int                edges;
		want    = expected_result(o, a, b);
		latency = o[2] ? muldiv_pkg::div_latency : muldiv_pkg::mul_latency;
		valid     = 1'b1;
		op        = o;
		operand_a = a;
		operand_b = b;
		// sampling edge lies between these two falling edges.
		@(negedge clk);
		edges = 0;
		valid = hold_valid;
		scramble_inputs();
		while (!ready && edges < latency + 8) begin
			// result register loads one edge ahead of ready.
			if (edges < latency - 1) begin
				check_value("held result", result, last_result);
			end
			@(negedge clk);
			edges++;
			scramble_inputs();
		end
		test_checks++;
		assert (edges == latency) else begin
			$display("at %0t ns: ready came %0d edges after the sampling edge instead of %0d",
				$time, edges, latency);
			test_errors++;
		end
		check_value("result", result, want);
		last_result = want;
		// ready must drop after one cycle while result stays.
		@(negedge clk);
		scramble_inputs();
		check_ready(1'b0);
		check_value("result after ready", result, want);
	endtask

	task automatic end_test(string name);
		$display("test %s: %0d checks, %0d errors", name, test_checks, test_errors);
		checks += test_checks;
		errors += test_errors;
		test_checks = 0;
		test_errors = 0;
	endtask

	// ----------------------------------------
	// test sequence
	// ----------------------------------------

	initial begin
		int                     r;
		muldiv_pkg::muldiv_op_t o;
		muldiv_pkg::xlen_t      a;
		muldiv_pkg::xlen_t      b;
		seed        = 32'h18bc;
		checks      = 0;
		errors      = 0;
		test_checks = 0;
		test_errors = 0;
		last_result = '0;
		rst_n       = 1'b0;
		valid       = 1'b0;
		op          = muldiv_pkg::op_mul;
		operand_a   = '0;
		operand_b   = '0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;

		// quiet after reset.
		for (int i = 0; i < 8; i++) begin
			@(negedge clk);
			check_ready(1'b0);
			check_value("result after reset", result, '0);
		end
		end_test("reset");

		for (int i = 0; i < n_mul; i++) begin
			r = $random(seed);
			o = muldiv_pkg::muldiv_op_t'({1'b0, r[1:0]});
			pick_operand(a);
			pick_operand(b);
			run_op(o, a, b, 1'b0);
		end
		end_test("multiply");

		for (int i = 0; i < n_div; i++) begin
			r = $random(seed);
			o = muldiv_pkg::muldiv_op_t'({1'b1, r[1:0]});
			pick_operand(a);
			pick_operand(b);
			run_op(o, a, b, 1'b0);
		end
		end_test("divide");

		// zero divisor and signed overflow on every divide op.
		for (int k = 0; k < 4; k++) begin
			o = muldiv_pkg::muldiv_op_t'({1'b1, k[1:0]});
			a = $random(seed);
			run_op(o, a, '0, 1'b0);
			run_op(o, 32'h8000_0000, '0, 1'b0);
			run_op(o, 32'h8000_0000, '1, 1'b0);
			run_op(o, a, '1, 1'b0);
		end
		end_test("divide corners");

		// valid never drops, so each op follows right after the last.
		for (int i = 0; i < n_b2b; i++) begin
			r = $random(seed);
			o = muldiv_pkg::muldiv_op_t'(r[2:0]);
			pick_operand(a);
			pick_operand(b);
			run_op(o, a, b, 1'b1);
		end
		valid = 1'b0;
		end_test("back to back");

		$display("total: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== build.f ====
verilog/muldiv_pkg.sv
verilog/muldiv_control.sv
verilog/operand_prep.sv
verilog/iter_multiplier.sv
verilog/restoring_divider.sv
verilog/result_fixup.sv
verilog/muldiv_unit.sv
bench/muldiv_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the muldiv testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
	-f build.f \
	--top-module muldiv_tb \
	-o muldiv_sim

./obj_dir/muldiv_sim | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

// ==== verilog/iter_multiplier.sv ====
module iter_multiplier (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 start,
	input  muldiv_pkg::xlen_t    factor0,
	input  muldiv_pkg::xlen_t    factor1,
	output logic                 done,
	output muldiv_pkg::dword_t   product
);

	// a * b split in halves:
	// (a_lo * b_lo) + (a_hi * b_lo) << 16 + (a_lo * b_hi) << 16 + (a_hi * b_hi) << 32.
	// one partial product per cycle goes into inter, then into acc a cycle later.

	logic               busy;
	logic [2:0]         step;
	muldiv_pkg::dword_t acc;
	muldiv_pkg::dword_t inter;

	muldiv_pkg::half_t  a_lo;
	muldiv_pkg::half_t  a_hi;
	muldiv_pkg::half_t  b_lo;
	muldiv_pkg::half_t  b_hi;

	muldiv_pkg::half_t  mult_in0;
	muldiv_pkg::half_t  mult_in1;
	muldiv_pkg::xlen_t  mult_out;
	logic [5:0]         shift_count;

	// ----------------------------------------
	// partial product selection
	// ----------------------------------------

	always_comb begin
		mult_in0    = b_lo;
		mult_in1    = a_lo;
		shift_count = 6'd0;
		case (step)
			3'd1: begin
				mult_in0    = b_lo;
				mult_in1    = a_hi;
				shift_count = 6'd16;
			end
			3'd2: begin
				mult_in0    = b_hi;
				mult_in1    = a_lo;
				shift_count = 6'd16;
			end
			3'd3: begin
				mult_in0    = b_hi;
				mult_in1    = a_hi;
				shift_count = 6'd32;
			end
			default: begin
				// step 0 uses the low halves, step 4 ignores the multiplier.
				mult_in0    = b_lo;
				mult_in1    = a_lo;
				shift_count = 6'd0;
			end
		endcase
	end

	// single 16x16 multiplier shared by all four products.
	assign mult_out = muldiv_pkg::xlen_t'(mult_in0) * muldiv_pkg::xlen_t'(mult_in1);

	// ----------------------------------------
	// sequencer and accumulator
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy <= 1'b0;
			done <= 1'b0;
			step <= 3'd0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy <= 1'b1;
					step <= 3'd0;
				end
			end else begin
				step <= step + 3'd1;
				// fifth accumulate lands the last product.
				if (step == 3'd4) begin
					done <= 1'b1;
					busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!busy) begin
			// load halves and clear sums only at start, so product holds.
			if (start) begin
				a_lo  <= factor0[15:0];
				a_hi  <= factor0[31:16];
				b_lo  <= factor1[15:0];
				b_hi  <= factor1[31:16];
				acc   <= '0;
				inter <= '0;
			end
		end else begin
			acc <= acc + inter;
			if (step < 3'd4) begin
				inter <= muldiv_pkg::dword_t'(mult_out) << shift_count;
			end else begin
				inter <= '0;
			end
		end
	end

	assign product = acc;

endmodule

// ==== verilog/muldiv_control.sv ====
module muldiv_control (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   valid,
	input  muldiv_pkg::muldiv_op_t op,
	output logic                   ready,
	output logic                   capture,
	output logic                   mul_start,
	output logic                   div_start,
	input  logic                   mul_done,
	input  logic                   div_done,
	output logic                   fix_en,
	output muldiv_pkg::muldiv_op_t op_q
);

	muldiv_pkg::ctrl_state_t state;

	// ----------------------------------------
	// strobes decoded from state
	// ----------------------------------------

	// new op is taken only in idle, and not in the cycle ready is high.
	assign capture = (state == muldiv_pkg::st_idle) && valid && !ready;

	// result is registered on the edge that sees the matching done.
	assign fix_en = ((state == muldiv_pkg::st_mul) && mul_done) ||
	                ((state == muldiv_pkg::st_div) && div_done);

	// ----------------------------------------
	// state machine
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state     <= muldiv_pkg::st_idle;
			ready     <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			op_q      <= muldiv_pkg::op_mul;
		end else begin
			// pulses default low.
			ready     <= 1'b0;
			mul_start <= 1'b0;
			div_start <= 1'b0;
			case (state)
				muldiv_pkg::st_idle: begin
					if (capture) begin
						op_q <= op;
						// bit 2 of the op selects the divider.
						if (op[2]) begin
							div_start <= 1'b1;
							state     <= muldiv_pkg::st_div;
						end else begin
							mul_start <= 1'b1;
							state     <= muldiv_pkg::st_mul;
						end
					end
				end
				muldiv_pkg::st_mul: begin
					// multiplier runs its five accumulate steps.
					if (mul_done) begin
						state <= muldiv_pkg::st_fix;
					end
				end
				muldiv_pkg::st_div: begin
					// divider runs load, 32 steps and a finish edge.
					if (div_done) begin
						state <= muldiv_pkg::st_fix;
					end
				end
				muldiv_pkg::st_fix: begin
					// result register was loaded on the way in here.
					ready <= 1'b1;
					state <= muldiv_pkg::st_idle;
				end
				default: begin
					state <= muldiv_pkg::st_idle;
				end
			endcase
		end
	end

endmodule

// ==== verilog/muldiv_pkg.sv ====
package muldiv_pkg;

	// ----------------------------------------
	// word widths
	// ----------------------------------------

	// width of one integer register of the core.
	localparam int xlen = 32;

	// one operand or result word.
	typedef logic [xlen-1:0] xlen_t;
	// full product of two words.
	typedef logic [2*xlen-1:0] dword_t;
	// one half of an operand, as fed to the 16x16 multiplier.
	typedef logic [xlen/2-1:0] half_t;

	// ----------------------------------------
	// operations and control
	// ----------------------------------------

	// M extension ops in funct3 order.
	// bit 2 set means divide or remainder.
	typedef enum logic [2:0] {
		op_mul    = 3'd0,
		op_mulh   = 3'd1,
		op_mulhsu = 3'd2,
		op_mulhu  = 3'd3,
		op_div    = 3'd4,
		op_divu   = 3'd5,
		op_rem    = 3'd6,
		op_remu   = 3'd7
	} muldiv_op_t;

	// sequencing states of the unit.
	typedef enum logic [1:0] {
		st_idle = 2'd0,
		st_mul  = 2'd1,
		st_div  = 2'd2,
		st_fix  = 2'd3
	} ctrl_state_t;

	// edges from the sampling edge of valid to the edge raising ready.
	localparam int mul_latency = 8;
	localparam int div_latency = 36;

endpackage

// ==== verilog/muldiv_unit.sv ====
module muldiv_unit (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   valid,
	input  muldiv_pkg::muldiv_op_t op,
	input  muldiv_pkg::xlen_t      operand_a,
	input  muldiv_pkg::xlen_t      operand_b,
	output logic                   ready,
	output muldiv_pkg::xlen_t      result
);

	// control strobes.
	logic                   capture;
	logic                   mul_start;
	logic                   div_start;
	logic                   mul_done;
	logic                   div_done;
	logic                   fix_en;
	muldiv_pkg::muldiv_op_t op_q;

	// conditioned operands.
	muldiv_pkg::xlen_t      mag_a;
	muldiv_pkg::xlen_t      mag_b;
	muldiv_pkg::xlen_t      operand_a_q;
	logic                   neg_result;
	logic                   neg_rem;
	logic                   div_zero;

	// datapath outputs.
	muldiv_pkg::dword_t     product;
	muldiv_pkg::xlen_t      quotient;
	muldiv_pkg::xlen_t      remainder;

	// ----------------------------------------
	// sequencing
	// ----------------------------------------

	muldiv_control u_control (
		.clk       (clk),
		.rst_n     (rst_n),
		.valid     (valid),
		.op        (op),
		.ready     (ready),
		.capture   (capture),
		.mul_start (mul_start),
		.div_start (div_start),
		.mul_done  (mul_done),
		.div_done  (div_done),
		.fix_en    (fix_en),
		.op_q      (op_q)
	);

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	operand_prep u_prep (
		.clk         (clk),
		.rst_n       (rst_n),
		.capture     (capture),
		.op          (op),
		.operand_a   (operand_a),
		.operand_b   (operand_b),
		.mag_a       (mag_a),
		.mag_b       (mag_b),
		.operand_a_q (operand_a_q),
		.neg_result  (neg_result),
		.neg_rem     (neg_rem),
		.div_zero    (div_zero)
	);

	iter_multiplier u_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.start   (mul_start),
		.factor0 (mag_a),
		.factor1 (mag_b),
		.done    (mul_done),
		.product (product)
	);

	restoring_divider u_div (
		.clk       (clk),
		.rst_n     (rst_n),
		.start     (div_start),
		.dividend  (mag_a),
		.divisor   (mag_b),
		.done      (div_done),
		.quotient  (quotient),
		.remainder (remainder)
	);

	result_fixup u_fixup (
		.clk        (clk),
		.rst_n      (rst_n),
		.fix_en     (fix_en),
		.op_q       (op_q),
		.product    (product),
		.quotient   (quotient),
		.remainder  (remainder),
		.neg_result (neg_result),
		.neg_rem    (neg_rem),
		.div_zero   (div_zero),
		.operand_a  (operand_a_q),
		.result     (result)
	);

endmodule

// ==== verilog/operand_prep.sv ====
module operand_prep (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   capture,
	input  muldiv_pkg::muldiv_op_t op,
	input  muldiv_pkg::xlen_t      operand_a,
	input  muldiv_pkg::xlen_t      operand_b,
	output muldiv_pkg::xlen_t      mag_a,
	output muldiv_pkg::xlen_t      mag_b,
	output muldiv_pkg::xlen_t      operand_a_q,
	output logic                   neg_result,
	output logic                   neg_rem,
	output logic                   div_zero
);

	logic signed_a;
	logic signed_b;
	logic neg_a;
	logic neg_b;

	// which operands are read as two's complement.
	// mulhsu treats only a as signed.
	always_comb begin
		signed_a = (op == muldiv_pkg::op_mulh) || (op == muldiv_pkg::op_mulhsu) ||
		           (op == muldiv_pkg::op_div)  || (op == muldiv_pkg::op_rem);
		signed_b = (op == muldiv_pkg::op_mulh) || (op == muldiv_pkg::op_div) ||
		           (op == muldiv_pkg::op_rem);
	end

	// an operand is negative only if it is signed and its msb is set.
	assign neg_a = signed_a && operand_a[31];
	assign neg_b = signed_b && operand_b[31];

	// flags.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			neg_result <= 1'b0;
			neg_rem    <= 1'b0;
			div_zero   <= 1'b0;
		end else if (capture) begin
			// remainder follows the dividend, quotient and product the xor.
			neg_result <= neg_a ^ neg_b;
			neg_rem    <= neg_a;
			div_zero   <= (operand_b == '0);
		end
	end

	// magnitudes, plus raw a for the divide by zero remainder.
	always_ff @(posedge clk) begin
		if (capture) begin
			mag_a       <= neg_a ? -operand_a : operand_a;
			mag_b       <= neg_b ? -operand_b : operand_b;
			operand_a_q <= operand_a;
		end
	end

endmodule

// ==== verilog/restoring_divider.sv ====
module restoring_divider (
	input  logic              clk,
	input  logic              rst_n,
	input  logic              start,
	input  muldiv_pkg::xlen_t dividend,
	input  muldiv_pkg::xlen_t divisor,
	output logic              done,
	output muldiv_pkg::xlen_t quotient,
	output muldiv_pkg::xlen_t remainder
);

	// one quotient bit per cycle, msb first.
	// quot starts as the dividend and shifts its bits into rem,
	// while the new quotient bits shift in from the right.

	logic              busy;
	logic [5:0]        count;
	muldiv_pkg::xlen_t quot;
	muldiv_pkg::xlen_t rem;
	muldiv_pkg::xlen_t divisor_q;

	logic [32:0]       shifted;
	logic [33:0]       diff;
	logic              fits;

	// ----------------------------------------
	// shift and trial subtract
	// ----------------------------------------

	always_comb begin
		// partial remainder with the next dividend bit appended.
		shifted = {rem, quot[31]};
		// one extra bit so the borrow shows as the sign.
		diff = {1'b0, shifted} - {2'b00, divisor_q};
		fits = !diff[33];
	end

	// ----------------------------------------
	// control
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy  <= 1'b0;
			done  <= 1'b0;
			count <= 6'd0;
		end else begin
			done <= 1'b0;
			if (!busy) begin
				if (start) begin
					busy  <= 1'b1;
					count <= 6'd0;
				end
			end else if (count == 6'(muldiv_pkg::xlen)) begin
				// all bits done, report on this extra edge.
				done <= 1'b1;
				busy <= 1'b0;
			end else begin
				count <= count + 6'd1;
			end
		end
	end

	// ----------------------------------------
	// datapath
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (!busy) begin
			if (start) begin
				quot      <= dividend;
				rem       <= '0;
				divisor_q <= divisor;
			end
		end else if (count != 6'(muldiv_pkg::xlen)) begin
			if (fits) begin
				// difference is below the divisor, so it fits in 32 bits.
				rem  <= diff[31:0];
				quot <= {quot[30:0], 1'b1};
			end else begin
				// restore, shifted is below the divisor here.
				rem  <= shifted[31:0];
				quot <= {quot[30:0], 1'b0};
			end
		end
	end

	// zero divisor always fits, which gives all ones and the dividend.
	assign quotient  = quot;
	assign remainder = rem;

endmodule

// ==== verilog/result_fixup.sv ====
module result_fixup (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   fix_en,
	input  muldiv_pkg::muldiv_op_t op_q,
	input  muldiv_pkg::dword_t     product,
	input  muldiv_pkg::xlen_t      quotient,
	input  muldiv_pkg::xlen_t      remainder,
	input  logic                   neg_result,
	input  logic                   neg_rem,
	input  logic                   div_zero,
	input  muldiv_pkg::xlen_t      operand_a,
	output muldiv_pkg::xlen_t      result
);

	muldiv_pkg::dword_t prod_fix;
	muldiv_pkg::xlen_t  quot_fix;
	muldiv_pkg::xlen_t  rem_fix;
	muldiv_pkg::xlen_t  next_result;

	// signs back onto the unsigned datapath outputs.
	assign prod_fix = neg_result ? -product : product;
	assign quot_fix = neg_result ? -quotient : quotient;
	assign rem_fix  = neg_rem ? -remainder : remainder;

	// ----------------------------------------
	// result select
	// ----------------------------------------

	always_comb begin
		next_result = prod_fix[31:0];
		case (op_q)
			muldiv_pkg::op_mul:    next_result = prod_fix[31:0];
			muldiv_pkg::op_mulh:   next_result = prod_fix[63:32];
			muldiv_pkg::op_mulhsu: next_result = prod_fix[63:32];
			muldiv_pkg::op_mulhu:  next_result = prod_fix[63:32];
			// divide by zero returns all ones.
			muldiv_pkg::op_div:    next_result = div_zero ? '1 : quot_fix;
			muldiv_pkg::op_divu:   next_result = div_zero ? '1 : quot_fix;
			// remainder by zero returns the dividend untouched.
			muldiv_pkg::op_rem:    next_result = div_zero ? operand_a : rem_fix;
			muldiv_pkg::op_remu:   next_result = div_zero ? operand_a : rem_fix;
			default:               next_result = prod_fix[31:0];
		endcase
	end

	// result holds until the next fix_en.
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			result <= '0;
		end else if (fix_en) begin
			result <= next_result;
		end
	end

endmodule
